// ==== all.f ====
+incdir+include
hw/idu_pkg.sv
hw/idu_decoder.sv
hw/idu_regfile.sv
hw/idu_bypass_ctrl.sv
hw/idu_issue_stage.sv
hw/idu_top.sv
verif/idu_tb.sv

// ==== Bender.yml ====
package:
  name: idu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/idu_pkg.sv
      - hw/idu_decoder.sv
      - hw/idu_regfile.sv
      - hw/idu_bypass_ctrl.sv
      - hw/idu_issue_stage.sv
      - hw/idu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/idu_tb.sv

// ==== verif/idu_tb.sv ====
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_tb;

    localparam int NUM_CYCLES  = 3000;
    localparam int HOLD_LIMIT  = 64;
    localparam int DRAIN_LIMIT = 32;

    typedef struct packed {
        logic [3:0]         alu_op;
        logic [`XLEN-1:0]   src_a;
        logic [`XLEN-1:0]   src_b;
        logic [`XLEN-1:0]   store_data;
        logic [`REG_AW-1:0] rd;
        logic               rf_we;
        logic               mem_rd;
        logic               mem_wr;
    } pkt_t;

    // Named after the DUT ports
    logic               clk_i;
    logic               rst_n_i;
    logic               in_valid_i;
    logic [`XLEN-1:0]   in_instr_i;
    logic [`XLEN-1:0]   in_pc_i;
    logic               in_ready_o;
    logic               wb_we_i;
    logic [`REG_AW-1:0] wb_addr_i;
    logic [`XLEN-1:0]   wb_data_i;
    logic               ex_valid_i;
    logic [`REG_AW-1:0] ex_rd_i;
    logic               ex_is_load_i;
    logic [`XLEN-1:0]   ex_data_i;
    logic               mem_valid_i;
    logic [`REG_AW-1:0] mem_rd_i;
    logic [`XLEN-1:0]   mem_data_i;
    logic               out_ready_i;
    logic               out_valid_o;
    idu_pkg::alu_op_e   out_alu_op_o;
    logic [`XLEN-1:0]   out_src_a_o;
    logic [`XLEN-1:0]   out_src_b_o;
    logic [`REG_AW-1:0] out_rd_o;
    logic               out_rf_we_o;
    logic               out_mem_rd_o;
    logic               out_mem_wr_o;
    logic [`XLEN-1:0]   out_store_data_o;

    // Reference model state
    logic [`XLEN-1:0] rf_model [32];
    pkt_t             exp_q [$];
    logic             exp_valid;
    logic             last_accept;
    logic [31:0]      lfsr_state;
    logic [`XLEN-1:0] next_pc;
    int               errors;
    int               checks;
    int               accepted;
    int               stalls;
    int               held;
    int               waited;
    logic             timed_out;

    idu_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // Registers limited to x0..x7 so dependences are frequent
    function automatic logic [`XLEN-1:0] random_instr();
        logic [`XLEN-1:0] w;
        logic [2:0]       cls;
        w        = rand_bits(32);
        cls      = 3'(rand_bits(3));
        w[11:7]  = 5'(rand_bits(3));
        w[19:15] = 5'(rand_bits(3));
        w[24:20] = 5'(rand_bits(3));
        case (cls)
            3'd0: w[6:0] = idu_pkg::OPC_LUI;
            3'd1: w[6:0] = idu_pkg::OPC_AUIPC;
            3'd2: w[6:0] = idu_pkg::OPC_OP_IMM;
            3'd3: begin
                w[6:0]   = idu_pkg::OPC_OP;
                w[31:25] = {1'b0, rand_bit(), 5'b0};
            end
            3'd4: w[6:0] = idu_pkg::OPC_LOAD;
            3'd5: w[6:0] = idu_pkg::OPC_STORE;
            3'd6: w[6:0] = idu_pkg::OPC_OP_IMM;
            default: w[6:0] = 7'b1100011;
        endcase
        return w;
    endfunction

    function automatic logic [3:0] expected_alu(input logic [2:0] f3, input logic bit30,
                                                input logic reg_form);
        logic [3:0] op;
        case (f3)
            3'b000: op = (reg_form && bit30) ? idu_pkg::ALU_SUB : idu_pkg::ALU_ADD;
            3'b001: op = idu_pkg::ALU_SLL;
            3'b010: op = idu_pkg::ALU_SLT;
            3'b011: op = idu_pkg::ALU_SLTU;
            3'b100: op = idu_pkg::ALU_XOR;
            3'b101: op = bit30 ? idu_pkg::ALU_SRA : idu_pkg::ALU_SRL;
            3'b110: op = idu_pkg::ALU_OR;
            default: op = idu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // EX first, then MEM, then the register file with write-through
    function automatic logic [`XLEN-1:0] operand(input logic [`REG_AW-1:0] rs, input logic used);
        if (rs == '0) begin
            return '0;
        end else if (used && ex_valid_i && ex_rd_i == rs) begin
            return ex_data_i;
        end else if (used && mem_valid_i && mem_rd_i == rs) begin
            return mem_data_i;
        end else if (wb_we_i && wb_addr_i == rs) begin
            return wb_data_i;
        end
        return rf_model[rs];
    endfunction

    task automatic model_decode(input logic [`XLEN-1:0] instr, output pkt_t p,
                                output logic stall);
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic               use1;
        logic               use2;
        logic               writes;
        rs1    = instr[19:15];
        rs2    = instr[24:20];
        use1   = 1'b0;
        use2   = 1'b0;
        writes = 1'b1;
        p      = '0;
        p.rd   = instr[11:7];
        case (instr[6:0])
            idu_pkg::OPC_LUI: p.src_b = {instr[31:12], 12'b0};
            idu_pkg::OPC_AUIPC: begin
                p.src_a = in_pc_i;
                p.src_b = {instr[31:12], 12'b0};
            end
            idu_pkg::OPC_OP_IMM: begin
                use1     = 1'b1;
                p.alu_op = expected_alu(instr[14:12], instr[30], 1'b0);
                p.src_b  = {{20{instr[31]}}, instr[31:20]};
            end
            idu_pkg::OPC_OP: begin
                use1     = 1'b1;
                use2     = 1'b1;
                p.alu_op = expected_alu(instr[14:12], instr[30], 1'b1);
                p.src_b  = operand(rs2, 1'b1);
            end
            idu_pkg::OPC_LOAD: begin
                use1     = 1'b1;
                p.mem_rd = 1'b1;
                p.src_b  = {{20{instr[31]}}, instr[31:20]};
            end
            idu_pkg::OPC_STORE: begin
                use1     = 1'b1;
                use2     = 1'b1;
                writes   = 1'b0;
                p.mem_wr = 1'b1;
                p.src_b  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            default: begin
                // Unsupported opcodes behave as ADDI x0, x0, 0
                writes = 1'b0;
                p.rd   = '0;
            end
        endcase
        if (use1) begin
            p.src_a = operand(rs1, 1'b1);
        end
        p.store_data = operand(rs2, use2);
        p.rf_we      = writes && (p.rd != '0);
        stall = ex_valid_i && ex_is_load_i && ((use1 && rs1 != '0 && ex_rd_i == rs1) ||
                                               (use2 && rs2 != '0 && ex_rd_i == rs2));
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: expected 0x%08h, got 0x%08h", $time, name, exp, got);
        end
    endtask

    // Called at the rising edge before the DUT registers update
    task automatic sample_edge();
        pkt_t p;
        pkt_t f;
        logic stall;
        logic ready;
        model_decode(in_instr_i, p, stall);
        ready       = !stall && (!exp_valid || out_ready_i);
        last_accept = in_valid_i && ready;
        compare("in_ready_o", 32'(in_ready_o), 32'(ready));
        compare("out_valid_o", 32'(out_valid_o), 32'(exp_valid));
        if (exp_valid) begin
            f = exp_q[0];
            compare("out_alu_op_o", 32'(out_alu_op_o), 32'(f.alu_op));
            compare("out_src_a_o", out_src_a_o, f.src_a);
            compare("out_src_b_o", out_src_b_o, f.src_b);
            compare("out_rd_o", 32'(out_rd_o), 32'(f.rd));
            compare("out_rf_we_o", 32'(out_rf_we_o), 32'(f.rf_we));
            compare("out_mem_rd_o", 32'(out_mem_rd_o), 32'(f.mem_rd));
            compare("out_mem_wr_o", 32'(out_mem_wr_o), 32'(f.mem_wr));
            if (f.mem_wr) begin
                compare("out_store_data_o", out_store_data_o, f.store_data);
            end
            if (out_ready_i) begin
                void'(exp_q.pop_front());
            end
        end
        if (stall && in_valid_i) begin
            stalls++;
        end
        if (last_accept) begin
            exp_q.push_back(p);
            accepted++;
        end
        exp_valid = last_accept || (exp_valid && !out_ready_i);
        if (wb_we_i && wb_addr_i != '0) begin
            rf_model[wb_addr_i] = wb_data_i;
        end
    endtask

    // Called on the falling edge
    task automatic drive_next();
        if (in_valid_i && !last_accept) begin
            held++;
            if (held > HOLD_LIMIT) begin
                errors++;
                timed_out = 1'b1;
                $display("ERROR: instruction at pc 0x%08h was not accepted within %0d cycles",
                         in_pc_i, HOLD_LIMIT);
            end
        end else begin
            held       = 0;
            in_valid_i = (rand_bits(2) != 0);
            in_instr_i = `NOP_INSTR;
            if (in_valid_i) begin
                in_instr_i = random_instr();
                in_pc_i    = next_pc;
                next_pc    = next_pc + 4;
            end
        end
        wb_we_i      = rand_bit();
        wb_addr_i    = 5'(rand_bits(3));
        wb_data_i    = rand_bits(32);
        ex_valid_i   = rand_bit();
        ex_rd_i      = 5'(rand_bits(3));
        ex_is_load_i = (rand_bits(2) == 0);
        ex_data_i    = rand_bits(32);
        mem_valid_i  = rand_bit();
        mem_rd_i     = 5'(rand_bits(3));
        mem_data_i   = rand_bits(32);
        out_ready_i  = (rand_bits(2) != 0);
    endtask

    initial begin
        lfsr_state   = 32'd22;
        next_pc      = 32'h0000_1000;
        errors       = 0;
        checks       = 0;
        accepted     = 0;
        stalls       = 0;
        held         = 0;
        waited       = 0;
        timed_out    = 1'b0;
        exp_valid    = 1'b0;
        last_accept  = 1'b0;
        rst_n_i      = 1'b0;
        in_valid_i   = 1'b0;
        in_instr_i   = `NOP_INSTR;
        in_pc_i      = '0;
        wb_we_i      = 1'b0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        ex_valid_i   = 1'b0;
        ex_rd_i      = '0;
        ex_is_load_i = 1'b0;
        ex_data_i    = '0;
        mem_valid_i  = 1'b0;
        mem_rd_i     = '0;
        mem_data_i   = '0;
        out_ready_i  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        compare("out_valid_o", 32'(out_valid_o), 32'd0);
        drive_next();

        for (int cyc = 0; cyc < NUM_CYCLES && !timed_out; cyc++) begin
            @(posedge clk_i);
            sample_edge();
            @(negedge clk_i);
            drive_next();
        end

        // Drain with no hazards and EX always ready
        ex_valid_i  = 1'b0;
        mem_valid_i = 1'b0;
        wb_we_i     = 1'b0;
        out_ready_i = 1'b1;
        while ((in_valid_i || exp_valid) && !timed_out) begin
            @(posedge clk_i);
            sample_edge();
            @(negedge clk_i);
            if (last_accept) begin
                in_valid_i = 1'b0;
                in_instr_i = `NOP_INSTR;
            end
            waited++;
            if (waited > DRAIN_LIMIT) begin
                errors++;
                timed_out = 1'b1;
                $display("ERROR: pipeline did not drain within %0d cycles", DRAIN_LIMIT);
            end
        end

        $display("checks: %0d, errors: %0d, accepted: %0d, stalled cycles: %0d",
                 checks, errors, accepted, stalls);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== hw/idu_top.sv ====
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Fetch side
    input  logic               in_valid_i,
    input  logic [`XLEN-1:0]   in_instr_i,
    input  logic [`XLEN-1:0]   in_pc_i,
    output logic               in_ready_o,
    // Writeback
    input  logic               wb_we_i,
    input  logic [`REG_AW-1:0] wb_addr_i,
    input  logic [`XLEN-1:0]   wb_data_i,
    // EX and MEM status
    input  logic               ex_valid_i,
    input  logic [`REG_AW-1:0] ex_rd_i,
    input  logic               ex_is_load_i,
    input  logic [`XLEN-1:0]   ex_data_i,
    input  logic               mem_valid_i,
    input  logic [`REG_AW-1:0] mem_rd_i,
    input  logic [`XLEN-1:0]   mem_data_i,
    // Issue toward EX
    input  logic               out_ready_i,
    output logic               out_valid_o,
    output idu_pkg::alu_op_e   out_alu_op_o,
    output logic [`XLEN-1:0]   out_src_a_o,
    output logic [`XLEN-1:0]   out_src_b_o,
    output logic [`REG_AW-1:0] out_rd_o,
    output logic               out_rf_we_o,
    output logic               out_mem_rd_o,
    output logic               out_mem_wr_o,
    output logic [`XLEN-1:0]   out_store_data_o
);

    idu_pkg::alu_op_e    alu_op;
    idu_pkg::src_a_sel_e src_a_sel;
    idu_pkg::src_b_sel_e src_b_sel;
    idu_pkg::bypass_e    byp_a;
    idu_pkg::bypass_e    byp_b;
    logic [`XLEN-1:0]    imm;
    logic [`XLEN-1:0]    rdata_a;
    logic [`XLEN-1:0]    rdata_b;
    logic [`REG_AW-1:0]  rs1;
    logic [`REG_AW-1:0]  rs2;
    logic [`REG_AW-1:0]  rd;
    logic                uses_rs1;
    logic                uses_rs2;
    logic                rf_we;
    logic                mem_rd;
    logic                mem_wr;
    logic                stall;

    idu_decoder u_decoder (
        .instr_i     (in_instr_i),
        .alu_op_o    (alu_op),
        .src_a_sel_o (src_a_sel),
        .src_b_sel_o (src_b_sel),
        .imm_o       (imm),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .uses_rs1_o  (uses_rs1),
        .uses_rs2_o  (uses_rs2),
        .rf_we_o     (rf_we),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr)
    );

    idu_regfile u_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_we_i),
        .waddr_i   (wb_addr_i),
        .wdata_i   (wb_data_i),
        .raddr_a_i (rs1),
        .raddr_b_i (rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    idu_bypass_ctrl u_bypass_ctrl (
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .uses_rs1_i   (uses_rs1),
        .uses_rs2_i   (uses_rs2),
        .ex_valid_i   (ex_valid_i),
        .ex_is_load_i (ex_is_load_i),
        .ex_rd_i      (ex_rd_i),
        .mem_valid_i  (mem_valid_i),
        .mem_rd_i     (mem_rd_i),
        .byp_a_o      (byp_a),
        .byp_b_o      (byp_b),
        .stall_o      (stall)
    );

    idu_issue_stage u_issue_stage (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .stall_i          (stall),
        .pc_i             (in_pc_i),
        .alu_op_i         (alu_op),
        .src_a_sel_i      (src_a_sel),
        .src_b_sel_i      (src_b_sel),
        .imm_i            (imm),
        .rdata_a_i        (rdata_a),
        .rdata_b_i        (rdata_b),
        .ex_data_i        (ex_data_i),
        .mem_data_i       (mem_data_i),
        .byp_a_i          (byp_a),
        .byp_b_i          (byp_b),
        .rd_i             (rd),
        .rf_we_i          (rf_we),
        .mem_rd_i         (mem_rd),
        .mem_wr_i         (mem_wr),
        .out_ready_i      (out_ready_i),
        .out_valid_o      (out_valid_o),
        .out_alu_op_o     (out_alu_op_o),
        .out_src_a_o      (out_src_a_o),
        .out_src_b_o      (out_src_b_o),
        .out_rd_o         (out_rd_o),
        .out_rf_we_o      (out_rf_we_o),
        .out_mem_rd_o     (out_mem_rd_o),
        .out_mem_wr_o     (out_mem_wr_o),
        .out_store_data_o (out_store_data_o)
    );

endmodule

// ==== hw/idu_issue_stage.sv ====
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_issue_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  logic                 stall_i,
    input  logic [`XLEN-1:0]     pc_i,
    input  idu_pkg::alu_op_e     alu_op_i,
    input  idu_pkg::src_a_sel_e  src_a_sel_i,
    input  idu_pkg::src_b_sel_e  src_b_sel_i,
    input  logic [`XLEN-1:0]     imm_i,
    input  logic [`XLEN-1:0]     rdata_a_i,
    input  logic [`XLEN-1:0]     rdata_b_i,
    input  logic [`XLEN-1:0]     ex_data_i,
    input  logic [`XLEN-1:0]     mem_data_i,
    input  idu_pkg::bypass_e     byp_a_i,
    input  idu_pkg::bypass_e     byp_b_i,
    input  logic [`REG_AW-1:0]   rd_i,
    input  logic                 rf_we_i,
    input  logic                 mem_rd_i,
    input  logic                 mem_wr_i,
    input  logic                 out_ready_i,
    output logic                 out_valid_o,
    output idu_pkg::alu_op_e     out_alu_op_o,
    output logic [`XLEN-1:0]     out_src_a_o,
    output logic [`XLEN-1:0]     out_src_b_o,
    output logic [`REG_AW-1:0]   out_rd_o,
    output logic                 out_rf_we_o,
    output logic                 out_mem_rd_o,
    output logic                 out_mem_wr_o,
    output logic [`XLEN-1:0]     out_store_data_o
);

    logic             accept;
    logic [`XLEN-1:0] opnd_a;
    logic [`XLEN-1:0] opnd_b;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;

    function automatic logic [`XLEN-1:0] fwd(input idu_pkg::bypass_e sel,
                                             input logic [`XLEN-1:0] rf_val,
                                             input logic [`XLEN-1:0] ex_val,
                                             input logic [`XLEN-1:0] mem_val);
        logic [`XLEN-1:0] val;
        case (sel)
            idu_pkg::BYP_EX:  val = ex_val;
            idu_pkg::BYP_MEM: val = mem_val;
            default:          val = rf_val;
        endcase
        return val;
    endfunction

    assign opnd_a = fwd(byp_a_i, rdata_a_i, ex_data_i, mem_data_i);
    assign opnd_b = fwd(byp_b_i, rdata_b_i, ex_data_i, mem_data_i);

    always_comb begin
        case (src_a_sel_i)
            idu_pkg::SRC_A_PC:   src_a = pc_i;
            idu_pkg::SRC_A_ZERO: src_a = '0;
            default:             src_a = opnd_a;
        endcase
    end

    assign src_b = (src_b_sel_i == idu_pkg::SRC_B_IMM) ? imm_i : opnd_b;

    // Accept when the register is empty or draining this cycle
    assign in_ready_o = !stall_i && (!out_valid_o || out_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o  <= 1'b0;
            out_rf_we_o  <= 1'b0;
            out_mem_rd_o <= 1'b0;
            out_mem_wr_o <= 1'b0;
        end else if (accept) begin
            out_valid_o  <= 1'b1;
            out_rf_we_o  <= rf_we_i;
            out_mem_rd_o <= mem_rd_i;
            out_mem_wr_o <= mem_wr_i;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_alu_op_o     <= alu_op_i;
            out_src_a_o      <= src_a;
            out_src_b_o      <= src_b;
            out_rd_o         <= rd_i;
            out_store_data_o <= opnd_b;
        end
    end

endmodule

// ==== hw/idu_bypass_ctrl.sv ====
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_bypass_ctrl (
    input  logic               [`REG_AW-1:0] rs1_i,
    input  logic               [`REG_AW-1:0] rs2_i,
    input  logic                             uses_rs1_i,
    input  logic                             uses_rs2_i,
    input  logic                             ex_valid_i,
    input  logic                             ex_is_load_i,
    input  logic               [`REG_AW-1:0] ex_rd_i,
    input  logic                             mem_valid_i,
    input  logic               [`REG_AW-1:0] mem_rd_i,
    output idu_pkg::bypass_e                 byp_a_o,
    output idu_pkg::bypass_e                 byp_b_o,
    output logic                             stall_o
);

    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;

    function automatic logic stage_match(input logic               valid,
                                         input logic [`REG_AW-1:0] rd,
                                         input logic [`REG_AW-1:0] rs);
        return valid && (rd == rs) && (rs != '0);
    endfunction

    // EX is younger than MEM, so it wins
    function automatic idu_pkg::bypass_e pick(input logic uses,
                                              input logic ex_hit,
                                              input logic mem_hit);
        idu_pkg::bypass_e sel;
        if (uses && ex_hit) begin
            sel = idu_pkg::BYP_EX;
        end else if (uses && mem_hit) begin
            sel = idu_pkg::BYP_MEM;
        end else begin
            sel = idu_pkg::BYP_NONE;
        end
        return sel;
    endfunction

    assign ex_hit_a  = stage_match(ex_valid_i, ex_rd_i, rs1_i);
    assign ex_hit_b  = stage_match(ex_valid_i, ex_rd_i, rs2_i);
    assign mem_hit_a = stage_match(mem_valid_i, mem_rd_i, rs1_i);
    assign mem_hit_b = stage_match(mem_valid_i, mem_rd_i, rs2_i);

    assign byp_a_o = pick(uses_rs1_i, ex_hit_a, mem_hit_a);
    assign byp_b_o = pick(uses_rs2_i, ex_hit_b, mem_hit_b);

    // Load data is not ready in EX yet
    assign stall_o = ex_is_load_i && ((uses_rs1_i && ex_hit_a) || (uses_rs2_i && ex_hit_b));

endmodule

// ==== hw/idu_regfile.sv ====
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_regfile (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               we_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]   wdata_i,
    input  logic [`REG_AW-1:0] raddr_a_i,
    input  logic [`REG_AW-1:0] raddr_b_i,
    output logic [`XLEN-1:0]   rdata_a_o,
    output logic [`XLEN-1:0]   rdata_b_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [31:1];
    logic             wr_en;

    assign wr_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through so a same-cycle writeback is visible to decode
    assign rdata_a_o = (raddr_a_i == '0)                  ? '0      :
                       (wr_en && (waddr_i == raddr_a_i)) ? wdata_i :
                                                           regs[raddr_a_i];

    assign rdata_b_o = (raddr_b_i == '0)                  ? '0      :
                       (wr_en && (waddr_i == raddr_b_i)) ? wdata_i :
                                                           regs[raddr_b_i];

endmodule

// ==== hw/idu_decoder.sv ====
`timescale 1ns/1ps
`include "idu_macros.svh"

module idu_decoder (
    input  logic [`XLEN-1:0]     instr_i,
    output idu_pkg::alu_op_e     alu_op_o,
    output idu_pkg::src_a_sel_e  src_a_sel_o,
    output idu_pkg::src_b_sel_e  src_b_sel_o,
    output logic [`XLEN-1:0]     imm_o,
    output logic [`REG_AW-1:0]   rs1_o,
    output logic [`REG_AW-1:0]   rs2_o,
    output logic [`REG_AW-1:0]   rd_o,
    output logic                 uses_rs1_o,
    output logic                 uses_rs2_o,
    output logic                 rf_we_o,
    output logic                 mem_rd_o,
    output logic                 mem_wr_o
);

    logic [`XLEN-1:0] instr;
    logic [6:0]       raw_opc;
    logic [2:0]       funct3;
    logic             funct7_b5;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;
    logic             writes_rd;

    function automatic idu_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
                                                        input logic       alt,
                                                        input logic       is_reg);
        idu_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? idu_pkg::ALU_SUB : idu_pkg::ALU_ADD;
            3'b001:  op = idu_pkg::ALU_SLL;
            3'b010:  op = idu_pkg::ALU_SLT;
            3'b011:  op = idu_pkg::ALU_SLTU;
            3'b100:  op = idu_pkg::ALU_XOR;
            3'b101:  op = alt ? idu_pkg::ALU_SRA : idu_pkg::ALU_SRL;
            3'b110:  op = idu_pkg::ALU_OR;
            default: op = idu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // Anything outside the subset is replaced by the canonical NOP
    assign raw_opc = instr_i[6:0];
    assign instr   = (raw_opc inside {idu_pkg::OPC_LUI, idu_pkg::OPC_AUIPC,
                                      idu_pkg::OPC_OP_IMM, idu_pkg::OPC_OP,
                                      idu_pkg::OPC_LOAD, idu_pkg::OPC_STORE})
                     ? instr_i : `NOP_INSTR;

    assign rd_o      = instr[11:7];
    assign rs1_o     = instr[19:15];
    assign rs2_o     = instr[24:20];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        alu_op_o    = idu_pkg::ALU_ADD;
        src_a_sel_o = idu_pkg::SRC_A_REG;
        src_b_sel_o = idu_pkg::SRC_B_IMM;
        imm_o       = imm_i;
        uses_rs1_o  = 1'b0;
        uses_rs2_o  = 1'b0;
        writes_rd   = 1'b0;
        mem_rd_o    = 1'b0;
        mem_wr_o    = 1'b0;
        case (idu_pkg::opcode_e'(instr[6:0]))
            idu_pkg::OPC_LUI: begin
                src_a_sel_o = idu_pkg::SRC_A_ZERO;
                imm_o       = imm_u;
                writes_rd   = 1'b1;
            end
            idu_pkg::OPC_AUIPC: begin
                src_a_sel_o = idu_pkg::SRC_A_PC;
                imm_o       = imm_u;
                writes_rd   = 1'b1;
            end
            idu_pkg::OPC_OP_IMM: begin
                alu_op_o   = alu_from_funct(funct3, funct7_b5, 1'b0);
                uses_rs1_o = 1'b1;
                writes_rd  = 1'b1;
            end
            idu_pkg::OPC_OP: begin
                alu_op_o    = alu_from_funct(funct3, funct7_b5, 1'b1);
                src_b_sel_o = idu_pkg::SRC_B_REG;
                uses_rs1_o  = 1'b1;
                uses_rs2_o  = 1'b1;
                writes_rd   = 1'b1;
            end
            idu_pkg::OPC_LOAD: begin
                uses_rs1_o = 1'b1;
                writes_rd  = 1'b1;
                mem_rd_o   = 1'b1;
            end
            idu_pkg::OPC_STORE: begin
                imm_o      = imm_s;
                uses_rs1_o = 1'b1;
                uses_rs2_o = 1'b1;
                mem_wr_o   = 1'b1;
            end
            default: ;
        endcase
    end

    // No write for x0 destinations
    assign rf_we_o = writes_rd && (rd_o != '0);

endmodule

// ==== hw/idu_pkg.sv ====
package idu_pkg;

    // Major opcodes of the decoded subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // ALU operand A source
    typedef enum logic [1:0] {
        SRC_A_REG  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_sel_e;

    // ALU operand B source
    typedef enum logic {
        SRC_B_REG = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_sel_e;

    // Where a source operand value comes from
    typedef enum logic [1:0] {
        BYP_NONE = 2'd0,
        BYP_EX   = 2'd1,
        BYP_MEM  = 2'd2
    } bypass_e;

endpackage

// ==== include/idu_macros.svh ====
`ifndef IDU_MACROS_SVH
`define IDU_MACROS_SVH

// Data path and instruction width
`define XLEN 32

// Register address width for 32 architectural registers
`define REG_AW 5

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
